//--- logic/be_pkg.sv
package be_pkg;

   // Integer and float registers share one 5-bit address space
   localparam int reg_addr_width_c = 5;

   // Widest supported pc; modules work on the low vaddr_width_p bits
   localparam int vaddr_width_max_c = 32;

   // Operation class of a decoded instruction
   typedef enum logic [2:0]
   {
      e_op_int      = 3'd0,
      e_op_mul      = 3'd1,
      e_op_load_int = 3'd2,
      e_op_load_fp  = 3'd3,
      e_op_store    = 3'd4,
      e_op_fp       = 3'd5,
      e_op_fence    = 3'd6,
      e_op_csr      = 3'd7   // serializing
   } be_op_e;

   // Issue-stage view of one instruction
   typedef struct packed
   {
      logic                         v;
      logic [vaddr_width_max_c-1:0] pc;
      logic [reg_addr_width_c-1:0]  rs1_addr;
      logic [reg_addr_width_c-1:0]  rs2_addr;
      logic                         irs1_v;
      logic                         irs2_v;
      logic                         frs1_v;
      logic                         frs2_v;
      logic                         mem_v;
      logic                         fence_v;
      logic [reg_addr_width_c-1:0]  rd_addr;
      be_op_e                       op;
   } be_isd_status_s;

   // Dependency entry carried by each pipe stage
   typedef struct packed
   {
      logic                         v;
      logic [reg_addr_width_c-1:0]  rd_addr;
      logic                         mul_iwb_v;
      logic                         mem_iwb_v;
      logic                         mem_fwb_v;
      logic                         fp_fwb_v;
      logic                         mem_v;
      logic                         serial_v;
      logic [vaddr_width_max_c-1:0] pc;
   } be_dep_status_s;

   // Entry 0 is ex1, then ex2, iwb and fwb
   typedef struct packed
   {
      be_dep_status_s [3:0]         dep_status;
      logic                         ex1_v;
      logic [vaddr_width_max_c-1:0] ex1_pc;
      logic                         mem3_miss_v;
   } be_calc_status_s;

   typedef enum logic [4:0]
   {
      e_csr_ctrl         = 5'h00,
      e_csr_stall_data   = 5'h04,
      e_csr_stall_struct = 5'h08,
      e_csr_poison       = 5'h0C,
      e_csr_roll         = 5'h10
   } be_csr_addr_e;

endpackage

//--- logic/be_issue_reg.sv
module be_issue_reg
   import be_pkg::*;
(
   input  logic           clk_i,
   input  logic           arst_n_i,

   // Decoded instruction from the front end
   input  be_isd_status_s isd_i,
   input  logic           issue_v_i,
   output logic           issue_ready_o,

   // Leave conditions from the detector
   input  logic           dispatch_i,
   input  logic           poison_i,

   output be_isd_status_s isd_o
);

   logic           v_q;
   logic           load;
   logic           leave;
   be_isd_status_s isd_q;

   // The entry frees up in the same cycle it dispatches or is squashed
   assign leave         = dispatch_i | poison_i;
   assign issue_ready_o = ~v_q | leave;
   assign load          = issue_v_i & issue_ready_o;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         v_q <= 1'b0;
      end
      else if (load)
      begin
         v_q <= 1'b1;
      end
      else if (leave)
      begin
         v_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (load)
      begin
         isd_q <= isd_i;
      end
   end

   always_comb
   begin
      isd_o   = isd_q;
      isd_o.v = v_q;
   end

endmodule

//--- logic/be_detector.sv
module be_detector
   import be_pkg::*;
#(
   parameter int vaddr_width_p = 32
)
(
   input  be_isd_status_s           isd_status_i,
   input  be_calc_status_s          calc_status_i,
   input  logic [vaddr_width_p-1:0] expected_npc_i,
   input  logic                     mmu_ready_i,
   input  logic                     credits_full_i,
   input  logic                     credits_empty_i,
   input  logic                     flush_i,

   output logic                     dispatch_v_o,
   output logic                     roll_o,
   output logic                     poison_isd_o,
   output logic                     poison_ex1_o,
   output logic                     poison_ex2_o,

   // Stall class of a held issue entry, for the event counters
   output logic                     stall_data_o,
   output logic                     stall_struct_o
);

   be_dep_status_s [3:0] dep;
   logic [2:0]           rs1_match;
   logic [2:0]           rs2_match;
   logic [2:0]           int_busy;
   logic [2:0]           fp_busy;
   logic [2:0]           irs_haz;
   logic [2:0]           frs_haz;
   logic                 data_haz;
   logic                 fence_haz;
   logic                 serial_haz;
   logic                 struct_haz;
   logic                 mem_in_pipe;
   logic                 mispredict;

   assign dep = calc_status_i.dep_status;

   always_comb
   begin
      // Results in ex1 that are not yet available for forwarding
      int_busy[0] = dep[0].mul_iwb_v | dep[0].mem_iwb_v;
      fp_busy[0]  = dep[0].mem_fwb_v | dep[0].fp_fwb_v;

      // In ex2 the multiplier has finished
      int_busy[1] = dep[1].mem_iwb_v;
      fp_busy[1]  = dep[1].mem_fwb_v | dep[1].fp_fwb_v;

      // Integer results in iwb are forwarded, only fp is still pending
      int_busy[2] = 1'b0;
      fp_busy[2]  = dep[2].fp_fwb_v;

      // fwb results are always forwarded, so only ex1 to iwb are checked
      for (int i = 0; i < 3; i++)
      begin
         rs1_match[i] = (isd_status_i.rs1_addr != '0)
                        & (isd_status_i.rs1_addr == dep[i].rd_addr);
         rs2_match[i] = (isd_status_i.rs2_addr != '0)
                        & (isd_status_i.rs2_addr == dep[i].rd_addr);

         irs_haz[i] = int_busy[i] & ((isd_status_i.irs1_v & rs1_match[i])
                                     | (isd_status_i.irs2_v & rs2_match[i]));
         frs_haz[i] = fp_busy[i] & ((isd_status_i.frs1_v & rs1_match[i])
                                    | (isd_status_i.frs2_v & rs2_match[i]));
      end
   end

   assign data_haz = (|irs_haz) | (|frs_haz);

   // Fence waits for all memory traffic to drain
   assign mem_in_pipe = dep[0].mem_v | dep[1].mem_v | dep[2].mem_v;
   assign fence_haz   = (isd_status_i.fence_v & (~credits_empty_i | mem_in_pipe))
                        | (isd_status_i.mem_v & credits_full_i);

   assign serial_haz = dep[0].serial_v | dep[1].serial_v | dep[2].serial_v | dep[3].serial_v;
   assign struct_haz = ~mmu_ready_i | fence_haz | serial_haz;

   assign mispredict = calc_status_i.ex1_v
                       & (calc_status_i.ex1_pc[vaddr_width_p-1:0] != expected_npc_i);

   assign dispatch_v_o = ~(data_haz | struct_haz);
   assign roll_o       = calc_status_i.mem3_miss_v;

   assign poison_isd_o = mispredict | flush_i | calc_status_i.mem3_miss_v;
   assign poison_ex1_o = mispredict | flush_i | calc_status_i.mem3_miss_v;
   // A mispredict is found in ex1, so ex2 is older and stays
   assign poison_ex2_o = flush_i | calc_status_i.mem3_miss_v;

   // A squashed entry is not counted as stalled
   assign stall_data_o   = isd_status_i.v & ~poison_isd_o & data_haz;
   assign stall_struct_o = isd_status_i.v & ~poison_isd_o & struct_haz;

endmodule

//--- logic/be_dep_pipe.sv
module be_dep_pipe
   import be_pkg::*;
#(
   parameter int vaddr_width_p = 32
)
(
   input  logic                     clk_i,
   input  logic                     arst_n_i,

   input  be_isd_status_s           isd_i,
   input  logic                     dispatch_i,
   input  logic                     poison_ex1_i,
   input  logic                     poison_ex2_i,
   input  logic                     mem_miss_i,

   output be_calc_status_s          calc_status_o,
   output logic                     retire_v_o,
   output logic [vaddr_width_p-1:0] retire_pc_o,
   output logic [vaddr_width_p-1:0] roll_pc_o
);

   be_dep_status_s       dep_new;
   be_dep_status_s [3:0] dep_q;
   logic                 mem3_miss_v;

   // Dependency entry of the instruction being dispatched
   always_comb
   begin
      dep_new         = '0;
      dep_new.v       = 1'b1;
      dep_new.rd_addr = isd_i.rd_addr;
      dep_new.pc      = isd_i.pc;
      case (isd_i.op)
         e_op_mul:      dep_new.mul_iwb_v = 1'b1;
         e_op_load_int:
         begin
            dep_new.mem_iwb_v = 1'b1;
            dep_new.mem_v     = 1'b1;
         end
         e_op_load_fp:
         begin
            dep_new.mem_fwb_v = 1'b1;
            dep_new.mem_v     = 1'b1;
         end
         e_op_store:    dep_new.mem_v     = 1'b1;
         e_op_fp:       dep_new.fp_fwb_v  = 1'b1;
         e_op_csr:      dep_new.serial_v  = 1'b1;
         // Simple integer ops and fences create no pending result
         default:       ;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         dep_q <= '0;
      end
      else
      begin
         dep_q[0] <= dispatch_i ? dep_new : '0;
         dep_q[1] <= poison_ex1_i ? '0 : dep_q[0];
         dep_q[2] <= poison_ex2_i ? '0 : dep_q[1];
         dep_q[3] <= dep_q[2];
      end
   end

   // Miss is reported while the memory op sits in fwb
   assign mem3_miss_v = dep_q[3].v & dep_q[3].mem_v & mem_miss_i;

   always_comb
   begin
      calc_status_o.dep_status  = dep_q;
      calc_status_o.ex1_v       = dep_q[0].v;
      calc_status_o.ex1_pc      = dep_q[0].pc;
      calc_status_o.mem3_miss_v = mem3_miss_v;
   end

   assign retire_v_o  = dep_q[3].v & ~mem3_miss_v;
   assign retire_pc_o = dep_q[3].pc[vaddr_width_p-1:0];
   assign roll_pc_o   = dep_q[3].pc[vaddr_width_p-1:0];

endmodule

//--- logic/be_mem_credits.sv
module be_mem_credits
#(
   parameter int credits_max_p = 4
)
(
   input  logic clk_i,
   input  logic arst_n_i,
   input  logic take_i,
   input  logic return_i,
   output logic full_o,
   output logic empty_o
);

   localparam int count_width_lp = $clog2(credits_max_p + 1);

   logic [count_width_lp-1:0] count_q;

   // Take and return in the same cycle cancel out
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         count_q <= '0;
      end
      else if (take_i & ~return_i & ~full_o)
      begin
         count_q <= count_q + 1'b1;
      end
      else if (return_i & ~take_i & ~empty_o)
      begin
         count_q <= count_q - 1'b1;
      end
   end

   assign full_o  = (count_q == count_width_lp'(credits_max_p));
   assign empty_o = (count_q == '0);

endmodule

//--- logic/be_chk_csr.sv
module be_chk_csr
   import be_pkg::*;
(
   input  logic                              clk_i,
   input  logic                              arst_n_i,

   // APB slave
   input  logic [$bits(be_csr_addr_e)-1:0]   paddr_i,
   input  logic                              psel_i,
   input  logic                              penable_i,
   input  logic                              pwrite_i,
   input  logic [31:0]                       pwdata_i,
   output logic [31:0]                       prdata_o,
   output logic                              pready_o,

   // Events from the detector
   input  logic                              stall_data_i,
   input  logic                              stall_struct_i,
   input  logic                              poison_i,
   input  logic                              roll_i,

   output logic                              flush_o,
   output logic                              dispatch_en_o
);

   logic             wr_en;
   logic             ctrl_wr;
   logic             flush_q;
   logic             dispatch_en_q;
   logic [3:0][31:0] cnt_q;
   logic [3:0]       cnt_inc;
   logic [3:0]       cnt_clr;

   // No wait states
   assign pready_o = 1'b1;
   assign wr_en    = psel_i & penable_i & pwrite_i;

   // Counter order: data stall, structural stall, poison, roll
   assign cnt_inc = {roll_i, poison_i, stall_struct_i, stall_data_i};

   always_comb
   begin
      prdata_o = '0;
      ctrl_wr  = 1'b0;
      cnt_clr  = '0;
      case (paddr_i)
         e_csr_ctrl:
         begin
            prdata_o = {30'b0, dispatch_en_q, 1'b0};
            ctrl_wr  = wr_en;
         end
         e_csr_stall_data:
         begin
            prdata_o   = cnt_q[0];
            cnt_clr[0] = wr_en;
         end
         e_csr_stall_struct:
         begin
            prdata_o   = cnt_q[1];
            cnt_clr[1] = wr_en;
         end
         e_csr_poison:
         begin
            prdata_o   = cnt_q[2];
            cnt_clr[2] = wr_en;
         end
         e_csr_roll:
         begin
            prdata_o   = cnt_q[3];
            cnt_clr[3] = wr_en;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         flush_q       <= 1'b0;
         dispatch_en_q <= 1'b1;
         cnt_q         <= '0;
      end
      else
      begin
         // Flush bit reads back as zero and lasts a single cycle
         flush_q <= ctrl_wr & pwdata_i[0];
         if (ctrl_wr)
         begin
            dispatch_en_q <= pwdata_i[1];
         end
         for (int i = 0; i < 4; i++)
         begin
            if (cnt_clr[i])
            begin
               cnt_q[i] <= '0;
            end
            else if (cnt_inc[i])
            begin
               cnt_q[i] <= cnt_q[i] + 32'd1;
            end
         end
      end
   end

   assign flush_o       = flush_q;
   assign dispatch_en_o = dispatch_en_q;

endmodule

//--- logic/be_checker_top.sv
module be_checker_top
   import be_pkg::*;
#(
   parameter int vaddr_width_p = 32,
   parameter int credits_max_p = 4
)
(
   input  logic                            clk_i,
   input  logic                            arst_n_i,

   // Front-end issue
   input  be_isd_status_s                  isd_i,
   input  logic                            issue_v_i,
   output logic                            issue_ready_o,

   input  logic [vaddr_width_p-1:0]        expected_npc_i,
   input  logic                            mmu_ready_i,
   input  logic                            mem_return_i,
   input  logic                            mem_miss_i,

   // APB
   input  logic [$bits(be_csr_addr_e)-1:0] paddr_i,
   input  logic                            psel_i,
   input  logic                            penable_i,
   input  logic                            pwrite_i,
   input  logic [31:0]                     pwdata_i,
   output logic [31:0]                     prdata_o,
   output logic                            pready_o,

   output logic                            dispatch_o,
   output logic                            retire_v_o,
   output logic [vaddr_width_p-1:0]        retire_pc_o,
   output logic                            roll_o,
   output logic [vaddr_width_p-1:0]        roll_pc_o
);

   be_isd_status_s  isd_status;
   be_calc_status_s calc_status;
   logic            dispatch_v;
   logic            dispatch;
   logic            poison_isd;
   logic            poison_ex1;
   logic            poison_ex2;
   logic            stall_data;
   logic            stall_struct;
   logic            credits_full;
   logic            credits_empty;
   logic            flush;
   logic            dispatch_en;
   logic            mmu_ready_gated;

   // Disabled dispatch looks like MMU back-pressure to the detector
   assign mmu_ready_gated = mmu_ready_i & dispatch_en;
   assign dispatch        = isd_status.v & dispatch_v & ~poison_isd;
   assign dispatch_o      = dispatch;

   be_issue_reg u_issue_reg (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .isd_i         (isd_i),
      .issue_v_i     (issue_v_i),
      .issue_ready_o (issue_ready_o),
      .dispatch_i    (dispatch),
      .poison_i      (poison_isd),
      .isd_o         (isd_status)
   );

   be_detector #(
      .vaddr_width_p (vaddr_width_p)
   ) u_detector (
      .isd_status_i    (isd_status),
      .calc_status_i   (calc_status),
      .expected_npc_i  (expected_npc_i),
      .mmu_ready_i     (mmu_ready_gated),
      .credits_full_i  (credits_full),
      .credits_empty_i (credits_empty),
      .flush_i         (flush),
      .dispatch_v_o    (dispatch_v),
      .roll_o          (roll_o),
      .poison_isd_o    (poison_isd),
      .poison_ex1_o    (poison_ex1),
      .poison_ex2_o    (poison_ex2),
      .stall_data_o    (stall_data),
      .stall_struct_o  (stall_struct)
   );

   be_dep_pipe #(
      .vaddr_width_p (vaddr_width_p)
   ) u_dep_pipe (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .isd_i         (isd_status),
      .dispatch_i    (dispatch),
      .poison_ex1_i  (poison_ex1),
      .poison_ex2_i  (poison_ex2),
      .mem_miss_i    (mem_miss_i),
      .calc_status_o (calc_status),
      .retire_v_o    (retire_v_o),
      .retire_pc_o   (retire_pc_o),
      .roll_pc_o     (roll_pc_o)
   );

   be_mem_credits #(
      .credits_max_p (credits_max_p)
   ) u_credits (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .take_i   (dispatch & isd_status.mem_v),
      .return_i (mem_return_i),
      .full_o   (credits_full),
      .empty_o  (credits_empty)
   );

   be_chk_csr u_csr (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .paddr_i        (paddr_i),
      .psel_i         (psel_i),
      .penable_i      (penable_i),
      .pwrite_i       (pwrite_i),
      .pwdata_i       (pwdata_i),
      .prdata_o       (prdata_o),
      .pready_o       (pready_o),
      .stall_data_i   (stall_data),
      .stall_struct_i (stall_struct),
      .poison_i       (poison_isd),
      .roll_i         (roll_o),
      .flush_o        (flush),
      .dispatch_en_o  (dispatch_en)
   );

endmodule

//--- verif/be_checker_monitor.sv
module be_checker_monitor
   import be_pkg::*;
#(
   parameter int vaddr_width_p = 32,
   parameter int credits_max_p = 4
)
(
   input  logic                            clk_i,
   input  logic                            arst_n_i,
   input  be_isd_status_s                  isd_i,
   input  logic                            issue_v_i,
   input  logic                            issue_ready_o,
   input  logic [vaddr_width_p-1:0]        expected_npc_i,
   input  logic                            mmu_ready_i,
   input  logic                            mem_return_i,
   input  logic                            mem_miss_i,
   input  logic [$bits(be_csr_addr_e)-1:0] paddr_i,
   input  logic                            psel_i,
   input  logic                            penable_i,
   input  logic                            pwrite_i,
   input  logic [31:0]                     pwdata_i,
   input  logic [31:0]                     prdata_o,
   input  logic                            dispatch_o,
   input  logic                            retire_v_o,
   input  logic [vaddr_width_p-1:0]        retire_pc_o,
   input  logic                            roll_o,
   input  logic [vaddr_width_p-1:0]        roll_pc_o,
   output int                              err_count_o,
   // Event counts: dispatch, data stall, fence dispatch, mispredict, roll, flush, read
   output int                              ev_o [7]
);

   timeunit 1ns;
   timeprecision 100ps;

   be_isd_status_s iss;
   be_isd_status_s st [4];
   int             credits;
   logic           en;
   logic           flush;
   logic [31:0]    cnt [4];

   // Integer result still pending in a stage
   function automatic logic int_pend(be_op_e op, int stage);
      if (stage == 0)
         return (op == e_op_mul) || (op == e_op_load_int);
      if (stage == 1)
         return op == e_op_load_int;
      return 1'b0;
   endfunction

   function automatic logic fp_pend(be_op_e op, int stage);
      if (stage < 2)
         return (op == e_op_load_fp) || (op == e_op_fp);
      return op == e_op_fp;
   endfunction

   function automatic logic is_mem(be_op_e op);
      return (op == e_op_load_int) || (op == e_op_load_fp) || (op == e_op_store);
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
      if (exp !== got)
      begin
         $display("Error at %0t: %s expected %h, got %h", $time, name, exp, got);
         err_count_o++;
      end
   endtask

   // Expected values are formed after the inputs settle, mid cycle
   always @(negedge clk_i or negedge arst_n_i)
   begin : model
      logic       data;
      logic       strct;
      logic       m1;
      logic       m2;
      logic       mem_pipe;
      logic       serial;
      logic       misp;
      logic       miss;
      logic       p_isd;
      logic       p_ex2;
      logic       disp;
      logic       ready;
      logic       wr_ctrl;
      logic [3:0] clr;
      logic [3:0] inc;
      logic [31:0] exp_rd;
      if (!arst_n_i)
      begin
         iss     = '0;
         credits = 0;
         en      = 1'b1;
         flush   = 1'b0;
         for (int i = 0; i < 4; i++)
         begin
            st[i]  = '0;
            cnt[i] = '0;
         end
      end
      else
      begin
         data     = 1'b0;
         mem_pipe = 1'b0;
         serial   = 1'b0;
         for (int i = 0; i < 4; i++)
         begin
            if (st[i].v && st[i].op == e_op_csr)
               serial = 1'b1;
         end
         for (int i = 0; i < 3; i++)
         begin
            if (st[i].v)
            begin
               m1 = (iss.rs1_addr != 0) && (iss.rs1_addr == st[i].rd_addr);
               m2 = (iss.rs2_addr != 0) && (iss.rs2_addr == st[i].rd_addr);
               if (int_pend(st[i].op, i) && ((iss.irs1_v && m1) || (iss.irs2_v && m2)))
                  data = 1'b1;
               if (fp_pend(st[i].op, i) && ((iss.frs1_v && m1) || (iss.frs2_v && m2)))
                  data = 1'b1;
               if (is_mem(st[i].op))
                  mem_pipe = 1'b1;
            end
         end
         strct = !mmu_ready_i || !en || serial
                 || (iss.fence_v && (credits != 0 || mem_pipe))
                 || (iss.mem_v && credits == credits_max_p);
         misp  = st[0].v && (st[0].pc != expected_npc_i);
         miss  = st[3].v && is_mem(st[3].op) && mem_miss_i;
         p_isd = misp || flush || miss;
         p_ex2 = flush || miss;
         disp  = iss.v && !data && !strct && !p_isd;
         ready = !iss.v || disp || p_isd;

         check("issue_ready_o", ready, issue_ready_o);
         check("dispatch_o", disp, dispatch_o);
         check("retire_v_o", st[3].v && !miss, retire_v_o);
         if (st[3].v && !miss)
            check("retire_pc_o", st[3].pc, retire_pc_o);
         check("roll_o", miss, roll_o);
         if (miss)
            check("roll_pc_o", st[3].pc, roll_pc_o);

         // APB access phase
         wr_ctrl = 1'b0;
         clr     = '0;
         if (psel_i && penable_i)
         begin
            case (paddr_i)
               e_csr_ctrl:         exp_rd = {30'b0, en, 1'b0};
               e_csr_stall_data:   exp_rd = cnt[0];
               e_csr_stall_struct: exp_rd = cnt[1];
               e_csr_poison:       exp_rd = cnt[2];
               e_csr_roll:         exp_rd = cnt[3];
               default:            exp_rd = '0;
            endcase
            if (pwrite_i)
            begin
               case (paddr_i)
                  e_csr_ctrl:         wr_ctrl = 1'b1;
                  e_csr_stall_data:   clr[0] = 1'b1;
                  e_csr_stall_struct: clr[1] = 1'b1;
                  e_csr_poison:       clr[2] = 1'b1;
                  e_csr_roll:         clr[3] = 1'b1;
                  default:            ;
               endcase
            end
            else
            begin
               check("prdata_o", exp_rd, prdata_o);
               ev_o[6]++;
            end
         end

         // Dispatches are counted as the DUT reports them
         if (dispatch_o)
            ev_o[0]++;
         if (iss.v && !p_isd && data)
            ev_o[1]++;
         if (disp && iss.fence_v)
            ev_o[2]++;
         if (misp)
            ev_o[3]++;
         if (miss)
            ev_o[4]++;
         if (flush)
            ev_o[5]++;

         inc = {miss, p_isd, iss.v && !p_isd && strct, iss.v && !p_isd && data};
         for (int i = 0; i < 4; i++)
            cnt[i] = clr[i] ? 32'd0 : cnt[i] + inc[i];
         flush = wr_ctrl && pwdata_i[0];
         if (wr_ctrl)
            en = pwdata_i[1];

         if (disp && iss.mem_v && !mem_return_i && credits < credits_max_p)
            credits++;
         else if (mem_return_i && !(disp && iss.mem_v) && credits > 0)
            credits--;

         // Advance the stages as at the next edge
         st[3] = st[2];
         st[2] = p_ex2 ? '0 : st[1];
         st[1] = p_isd ? '0 : st[0];
         st[0] = disp ? iss : '0;
         if (issue_v_i && ready)
         begin
            iss   = isd_i;
            iss.v = 1'b1;
         end
         else if (disp || p_isd)
            iss.v = 1'b0;
      end
   end

   initial
   begin
      err_count_o = 0;
      for (int i = 0; i < 7; i++)
         ev_o[i] = 0;
   end

endmodule

//--- verif/be_checker_checker.sv
module be_checker_checker
#(
   parameter int credits_max_p = 4
)
(
   input  logic                                 clk_i,
   input  logic                                 arst_n_i,
   input  logic                                 isd_v_i,
   input  logic                                 dispatch_i,
   input  logic                                 poison_i,
   input  logic                                 roll_i,
   input  logic [2:0]                           stage_v_i,
   input  logic [$clog2(credits_max_p + 1)-1:0] count_i
);

   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;

   // A held entry stays until it dispatches or is squashed
   a_entry_kept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      isd_v_i && !dispatch_i && !poison_i |=> isd_v_i)
   else
   begin
      $error("issue entry dropped without dispatch or poison");
      fail_count++;
   end

   // A roll leaves ex1, ex2 and iwb empty at the next edge
   a_roll_poison: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      roll_i |=> stage_v_i == 3'b000)
   else
   begin
      $error("roll did not squash the younger stages");
      fail_count++;
   end

   a_credit_limit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      count_i <= credits_max_p)
   else
   begin
      $error("memory credits above their limit");
      fail_count++;
   end

endmodule

bind be_checker_top be_checker_checker #(
   .credits_max_p (credits_max_p)
) u_chk (
   .clk_i      (clk_i),
   .arst_n_i   (arst_n_i),
   .isd_v_i    (isd_status.v),
   .dispatch_i (dispatch),
   .poison_i   (poison_isd),
   .roll_i     (roll_o),
   .stage_v_i  ({calc_status.dep_status[2].v,
                 calc_status.dep_status[1].v,
                 calc_status.dep_status[0].v}),
   .count_i    (u_credits.count_q)
);

//--- verif/be_checker_tb.sv
module be_checker_tb;

   import be_pkg::*;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int vaddr_width_p = 32;
   localparam int credits_max_p = 4;

   logic                            clk_i;
   logic                            arst_n_i;
   be_isd_status_s                  isd_i;
   logic                            issue_v_i;
   logic                            issue_ready_o;
   logic [vaddr_width_p-1:0]        expected_npc_i;
   logic                            mmu_ready_i;
   logic                            mem_return_i;
   logic                            mem_miss_i;
   logic [$bits(be_csr_addr_e)-1:0] paddr_i;
   logic                            psel_i;
   logic                            penable_i;
   logic                            pwrite_i;
   logic [31:0]                     pwdata_i;
   logic [31:0]                     prdata_o;
   logic                            pready_o;
   logic                            dispatch_o;
   logic                            retire_v_o;
   logic [vaddr_width_p-1:0]        retire_pc_o;
   logic                            roll_o;
   logic [vaddr_width_p-1:0]        roll_pc_o;

   int   mon_errs;
   int   ev [7];
   int   seed = 32'hf2760fff;
   int   fails = 0;
   int   tests_failed = 0;
   logic stim_on = 1'b0;
   logic mem_bias = 1'b0;
   int   misp_th = 4;
   int   miss_th = 8;
   logic [31:0] pc_next = 32'h1000;

   be_checker_top #(
      .vaddr_width_p (vaddr_width_p),
      .credits_max_p (credits_max_p)
   ) uut (.*);

   be_checker_monitor #(
      .vaddr_width_p (vaddr_width_p),
      .credits_max_p (credits_max_p)
   ) u_mon (.*, .err_count_o(mon_errs), .ev_o(ev));

   always #5 clk_i = ~clk_i;

   // Random front end, pc check, MMU and memory responses
   always @(posedge clk_i)
   begin : stimulus
      logic [31:0] r;
      logic [31:0] s;
      be_op_e      op;
      if (stim_on)
      begin
         r = $random(seed);
         s = $random(seed);
         if (!issue_v_i || issue_ready_o)
         begin
            op = be_op_e'(r[2:0]);
            if (mem_bias && r[3])
               op = r[4] ? e_op_fence : (r[5] ? e_op_store : e_op_load_fp);
            isd_i.v        <= 1'b1;
            isd_i.pc       <= pc_next;
            isd_i.op       <= op;
            isd_i.rs1_addr <= {2'b0, s[2:0]};
            isd_i.rs2_addr <= {2'b0, s[5:3]};
            isd_i.rd_addr  <= {2'b0, s[8:6]};
            isd_i.irs1_v   <= s[9];
            isd_i.irs2_v   <= s[10];
            isd_i.frs1_v   <= s[11];
            isd_i.frs2_v   <= s[12];
            isd_i.mem_v    <= op inside {e_op_load_int, e_op_load_fp, e_op_store};
            isd_i.fence_v  <= op == e_op_fence;
            issue_v_i      <= r[6] | r[7];
            pc_next = pc_next + 32'd4;
         end
         // The issue entry's pc is what ex1 holds after a dispatch
         if (s[20:13] < misp_th)
            expected_npc_i <= uut.isd_status.pc ^ 32'h4;
         else
            expected_npc_i <= uut.isd_status.pc;
         mmu_ready_i  <= r[10:8] != 3'd0;
         mem_return_i <= r[12:11] == 2'd0;
         mem_miss_i   <= r[20:13] < miss_th;
      end
   end

   function automatic int total_errs();
      return mon_errs + uut.u_chk.fail_count + fails;
   endfunction

   task automatic run_cycles(input int n);
      repeat (n) @(posedge clk_i);
   endtask

   task automatic wait_event(input int idx, input int target, input string what);
      int n;
      n = 0;
      while (ev[idx] < target && n < 5000)
      begin
         @(posedge clk_i);
         n++;
      end
      if (ev[idx] < target)
      begin
         $display("Timeout: %s did not occur %0d times", what, target);
         fails++;
      end
   endtask

   task automatic apb_xfer(input be_csr_addr_e addr, input logic wr, input logic [31:0] data);
      int n;
      n = 0;
      psel_i    <= 1'b1;
      penable_i <= 1'b0;
      paddr_i   <= addr;
      pwrite_i  <= wr;
      pwdata_i  <= data;
      @(posedge clk_i);
      penable_i <= 1'b1;
      @(posedge clk_i);
      while (!pready_o && n < 50)
      begin
         @(posedge clk_i);
         n++;
      end
      if (!pready_o)
      begin
         $display("Timeout: APB transfer got no pready");
         fails++;
      end
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
   endtask

   task automatic report(input string name, input int errs_before);
      if (total_errs() == errs_before)
         $display("Test %s: ok", name);
      else
      begin
         $display("Test %s: failed with %0d errors", name, total_errs() - errs_before);
         tests_failed++;
      end
   endtask

   initial
   begin : main
      int e;
      int d;
      clk_i          = 1'b0;
      arst_n_i       = 1'b0;
      isd_i          = '0;
      issue_v_i      = 1'b0;
      expected_npc_i = '0;
      mmu_ready_i    = 1'b1;
      mem_return_i   = 1'b0;
      mem_miss_i     = 1'b0;
      paddr_i        = '0;
      psel_i         = 1'b0;
      penable_i      = 1'b0;
      pwrite_i       = 1'b0;
      pwdata_i       = '0;
      run_cycles(2);
      arst_n_i <= 1'b1;
      stim_on  <= 1'b1;

      e = total_errs();
      wait_event(0, 60, "dispatch");
      wait_event(1, 20, "data stall");
      report("raw hazard", e);

      e        = total_errs();
      mem_bias = 1'b1;
      wait_event(2, 5, "fence dispatch");
      report("fence and credits", e);

      e       = total_errs();
      misp_th = 40;
      wait_event(3, 15, "mispredict");
      misp_th = 4;
      report("mispredict", e);

      e       = total_errs();
      miss_th = 120;
      wait_event(4, 8, "roll");
      miss_th = 8;
      mem_bias = 1'b0;
      report("memory miss", e);

      e = total_errs();
      repeat (3)
      begin
         apb_xfer(e_csr_ctrl, 1'b1, 32'h3);
         run_cycles(3);
      end
      wait_event(5, 3, "flush");
      apb_xfer(e_csr_ctrl, 1'b1, 32'h0);
      run_cycles(1);
      d = ev[0];
      run_cycles(40);
      if (ev[0] != d)
      begin
         $display("Dispatch happened while dispatch was disabled");
         fails++;
      end
      apb_xfer(e_csr_ctrl, 1'b1, 32'h2);
      report("flush and disable", e);

      e = total_errs();
      d = ev[6];
      apb_xfer(e_csr_ctrl, 1'b0, 32'h0);
      apb_xfer(e_csr_stall_data, 1'b0, 32'h0);
      apb_xfer(e_csr_stall_struct, 1'b0, 32'h0);
      apb_xfer(e_csr_poison, 1'b0, 32'h0);
      apb_xfer(e_csr_roll, 1'b0, 32'h0);
      apb_xfer(e_csr_poison, 1'b1, 32'h0);
      apb_xfer(e_csr_poison, 1'b0, 32'h0);
      wait_event(6, d + 6, "counter read");
      report("counter reads", e);

      stim_on <= 1'b0;
      run_cycles(2);
      $display("Tests run: 6, failed: %0d, errors: %0d", tests_failed, total_errs());
      if (total_errs() == 0 && tests_failed == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

//--- compile.f
logic/be_pkg.sv
logic/be_issue_reg.sv
logic/be_detector.sv
logic/be_dep_pipe.sv
logic/be_mem_credits.sv
logic/be_chk_csr.sv
logic/be_checker_top.sv
verif/be_checker_monitor.sv
verif/be_checker_checker.sv
verif/be_checker_tb.sv
